// ==== hw/lv_pkg.sv ====
`default_nettype none

package lv_pkg;

    // ================================================
    // widths
    // ================================================
    localparam int REG_AW      = 7;
    localparam int REG_DW      = 8;
    localparam int SPI_FRAME_W = 16;
    localparam int DLY_W       = 4;
    localparam int ST_W        = 3;

    // control fsm state codes
    localparam logic [ST_W-1:0] WAIT_ST   = 3'd0;
    localparam logic [ST_W-1:0] NORMAL_ST = 3'd1;
    localparam logic [ST_W-1:0] CFG_ST    = 3'd2;
    localparam logic [ST_W-1:0] FAULT_ST  = 3'd3;

    // ================================================
    // register map
    // ================================================
    localparam logic [REG_AW-1:0] ADDR_MODE    = 7'h00;
    localparam logic [REG_AW-1:0] ADDR_CONFIG0 = 7'h01;
    localparam logic [REG_AW-1:0] ADDR_STATUS1 = 7'h02;
    localparam logic [REG_AW-1:0] ADDR_STATUS2 = 7'h03;
    localparam logic [REG_AW-1:0] ADDR_STATUS3 = 7'h04;
    localparam logic [REG_AW-1:0] ADDR_STATUS4 = 7'h05;

    localparam logic [REG_DW-1:0] CONFIG0_RST  = 8'h03;

    typedef struct packed {
        logic              wen;    // one-cycle strobes
        logic              ren;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic reset_en;
        logic cfg_en;
        logic normal_en;   // MODE bit 0
    } mode_cmd_t;

    typedef struct packed {
        logic spi_err;
        logic pwm_dterr;
        logic pwm_mmerr;
        logic vsup_ov;
        logic vsup_uv;
    } lv_err_t;

    // order matches STATUS3 bits 5..0
    typedef struct packed {
        logic io_pwma;
        logic io_pwm;
        logic io_fsstate;
        logic io_fsenb_n;
        logic io_intb;
        logic io_inta;
    } io_pins_t;

endpackage

`default_nettype wire

// ==== hw/lv_in_sync.sv ====
`default_nettype none

module lv_in_sync #(
    parameter int WIDTH = 1
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data
);

    logic [WIDTH-1:0] meta;   // first stage, may go metastable

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            meta   <= '0;
            o_data <= '0;
        end else begin
            meta   <= i_data;
            o_data <= meta;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lv_spi_slv.sv ====
`default_nettype none

module lv_spi_slv (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_sclk,
    input  logic                      i_csb,
    input  logic                      i_mosi,
    output logic                      o_spi_miso,
    output lv_pkg::reg_req_t          o_req,
    input  logic [lv_pkg::REG_DW-1:0] i_rdata,
    output logic                      o_spi_err
);

    localparam int              CNT_W = $clog2(lv_pkg::SPI_FRAME_W + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(lv_pkg::SPI_FRAME_W);
    localparam logic [CNT_W-1:0] HDR  = CNT_W'(lv_pkg::SPI_FRAME_W - lv_pkg::REG_DW);

    logic                           sclk_d;
    logic                           csb_d;
    logic [CNT_W-1:0]               bit_cnt;
    logic                           bit_done;   // cnt and rx_sr hold the new bit
    logic                           rd_act;
    logic                           miso_q;
    logic                           spi_err_q;
    logic [lv_pkg::SPI_FRAME_W-1:0] rx_sr;
    logic [lv_pkg::REG_DW-1:0]      tx_sr;
    logic                           sclk_rise;
    logic                           sclk_fall;
    logic                           csb_rise;
    logic                           take;
    logic                           shift_out;

    assign sclk_rise = i_sclk & ~sclk_d;
    assign sclk_fall = ~i_sclk & sclk_d;
    assign csb_rise  = i_csb & ~csb_d;
    assign take      = sclk_rise & ~i_csb & (bit_cnt != LAST);
    // miso moves on falls after the header, read frames only
    assign shift_out = sclk_fall & ~i_csb & rd_act & (bit_cnt >= HDR) & (bit_cnt != LAST);

    // ================================================
    // register request
    // ================================================
    always_comb begin
        o_req.ren   = bit_done && (bit_cnt == HDR) && !rx_sr[lv_pkg::REG_DW-1];
        o_req.wen   = bit_done && (bit_cnt == LAST) && rx_sr[lv_pkg::SPI_FRAME_W-1];
        o_req.wdata = rx_sr[lv_pkg::REG_DW-1:0];
        if (bit_cnt == LAST) begin
            o_req.addr = rx_sr[lv_pkg::SPI_FRAME_W-2 -: lv_pkg::REG_AW];
        end else begin
            o_req.addr = rx_sr[lv_pkg::REG_AW-1:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sclk_d    <= 1'b0;
            csb_d     <= 1'b1;   // idle high, no false rise
            bit_cnt   <= '0;
            bit_done  <= 1'b0;
            rd_act    <= 1'b0;
            miso_q    <= 1'b0;
            spi_err_q <= 1'b0;
        end else begin
            sclk_d    <= i_sclk;
            csb_d     <= i_csb;
            bit_done  <= take;
            spi_err_q <= csb_rise && (bit_cnt != LAST);
            if (i_csb) begin
                bit_cnt <= '0;
                rd_act  <= 1'b0;
                miso_q  <= 1'b0;
            end else begin
                if (take) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (o_req.ren) begin
                    rd_act <= 1'b1;
                end
                if (shift_out) begin
                    miso_q <= tx_sr[lv_pkg::REG_DW-1];
                end
            end
        end
    end

    // shift registers
    always_ff @(posedge i_clk) begin
        if (take) begin
            rx_sr <= {rx_sr[lv_pkg::SPI_FRAME_W-2:0], i_mosi};   // msb first
        end
        if (o_req.ren) begin
            tx_sr <= i_rdata;
        end else if (shift_out) begin
            tx_sr <= {tx_sr[lv_pkg::REG_DW-2:0], 1'b0};
        end
    end

    assign o_spi_miso = miso_q;
    assign o_spi_err  = spi_err_q;

    a_req_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_req.wen || o_req.ren) |=> !(o_req.wen || o_req.ren));

endmodule

`default_nettype wire

// ==== hw/lv_reg_slv.sv ====
`default_nettype none

module lv_reg_slv (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  lv_pkg::reg_req_t           i_req,
    output logic [lv_pkg::REG_DW-1:0]  o_rdata,
    input  lv_pkg::lv_err_t            i_err,
    input  logic                       i_vsup_ov,
    input  logic                       i_vsup_uv,
    input  lv_pkg::io_pins_t           i_pins,
    input  logic [lv_pkg::ST_W-1:0]    i_state,
    input  logic                       i_cfg_st_reg_en,
    output lv_pkg::mode_cmd_t          o_mode_cmd,
    output logic                       o_any_err,
    output logic [lv_pkg::DLY_W-1:0]   o_vge_mon_dly
);

    logic [lv_pkg::REG_DW-1:0] config0;
    logic [lv_pkg::REG_DW-1:0] status1;
    logic [lv_pkg::REG_DW-1:0] status2;
    logic [lv_pkg::REG_DW-1:0] st1_set;
    logic [lv_pkg::REG_DW-1:0] st2_set;
    logic [lv_pkg::REG_DW-1:0] rdata;
    lv_pkg::mode_cmd_t         mode_q;
    lv_pkg::lv_err_t           err_p;
    logic                      ov_d;
    logic                      uv_d;
    logic                      wr_st1;
    logic                      wr_st2;

    assign wr_st1 = i_req.wen && (i_req.addr == lv_pkg::ADDR_STATUS1);
    assign wr_st2 = i_req.wen && (i_req.addr == lv_pkg::ADDR_STATUS2);

    // supply faults are taken on the rising edge
    always_comb begin
        err_p         = i_err;
        err_p.vsup_ov = i_err.vsup_ov | (i_vsup_ov & ~ov_d);
        err_p.vsup_uv = i_err.vsup_uv | (i_vsup_uv & ~uv_d);
    end

    assign st1_set = {2'b00, err_p.pwm_mmerr, err_p.pwm_dterr, 3'b000, err_p.spi_err};
    assign st2_set = {6'b000000, err_p.vsup_ov, err_p.vsup_uv};

    // ================================================
    // registers
    // ================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mode_q  <= '0;
            config0 <= lv_pkg::CONFIG0_RST;
            status1 <= '0;
            status2 <= '0;
            ov_d    <= 1'b0;
            uv_d    <= 1'b0;
        end else begin
            ov_d   <= i_vsup_ov;
            uv_d   <= i_vsup_uv;
            mode_q <= '0;   // command bits only last one cycle
            if (i_req.wen && (i_req.addr == lv_pkg::ADDR_MODE)) begin
                mode_q <= lv_pkg::mode_cmd_t'(i_req.wdata[2:0]);
            end
            if (i_req.wen && (i_req.addr == lv_pkg::ADDR_CONFIG0) && i_cfg_st_reg_en) begin
                config0 <= i_req.wdata;
            end
            // w1c, a new error wins over the clear
            status1 <= (status1 & ~(wr_st1 ? i_req.wdata : '0)) | st1_set;
            status2 <= (status2 & ~(wr_st2 ? i_req.wdata : '0)) | st2_set;
        end
    end

    always_comb begin
        case (i_req.addr)
            lv_pkg::ADDR_CONFIG0: rdata = config0;
            lv_pkg::ADDR_STATUS1: rdata = status1;
            lv_pkg::ADDR_STATUS2: rdata = status2;
            lv_pkg::ADDR_STATUS3: rdata = {2'b00, i_pins};
            lv_pkg::ADDR_STATUS4: rdata = {{(lv_pkg::REG_DW - lv_pkg::ST_W){1'b0}}, i_state};
            default:              rdata = '0;   // MODE and holes
        endcase
        o_rdata = i_req.ren ? rdata : '0;
    end

    assign o_mode_cmd    = mode_q;
    assign o_any_err     = |{status1, status2};
    assign o_vge_mon_dly = config0[lv_pkg::DLY_W-1:0];

    a_st1_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        |($past(status1) & ~status1) |-> $past(wr_st1));
    a_st2_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        |($past(status2) & ~status2) |-> $past(wr_st2));

endmodule

`default_nettype wire

// ==== hw/lv_ctrl_unit.sv ====
`default_nettype none

module lv_ctrl_unit (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  lv_pkg::mode_cmd_t       i_mode_cmd,
    input  logic                    i_any_err,
    input  logic                    i_io_fsenb_n,
    output logic [lv_pkg::ST_W-1:0] o_state,
    output logic                    o_cfg_st_reg_en,
    output logic                    o_dgt_ang_pwm_en,
    output logic                    o_dgt_ang_fsc_en,
    output logic                    o_intb_n
);

    logic [lv_pkg::ST_W-1:0] state;
    logic [lv_pkg::ST_W-1:0] state_nxt;
    logic                    fault;
    logic                    intb_q;

    assign fault = i_any_err || !i_io_fsenb_n;

    // ================================================
    // next state
    // ================================================
    always_comb begin
        state_nxt = state;
        case (state)
            lv_pkg::WAIT_ST: begin
                if (fault) begin
                    state_nxt = lv_pkg::FAULT_ST;
                end else if (i_mode_cmd.normal_en) begin
                    state_nxt = lv_pkg::NORMAL_ST;
                end else if (i_mode_cmd.cfg_en) begin
                    state_nxt = lv_pkg::CFG_ST;
                end
            end
            lv_pkg::NORMAL_ST: begin
                if (fault) begin
                    state_nxt = lv_pkg::FAULT_ST;
                end else if (i_mode_cmd.cfg_en) begin
                    state_nxt = lv_pkg::CFG_ST;
                end
            end
            lv_pkg::CFG_ST: begin
                if (fault) begin
                    state_nxt = lv_pkg::FAULT_ST;
                end else if (i_mode_cmd.normal_en) begin
                    state_nxt = lv_pkg::NORMAL_ST;
                end
            end
            lv_pkg::FAULT_ST: begin
                // leave only once the cause is gone
                if (i_mode_cmd.reset_en && !fault) begin
                    state_nxt = lv_pkg::WAIT_ST;
                end
            end
            default: state_nxt = lv_pkg::WAIT_ST;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= lv_pkg::WAIT_ST;
            intb_q <= 1'b1;
        end else begin
            state  <= state_nxt;
            intb_q <= !i_any_err;
        end
    end

    assign o_state          = state;
    assign o_cfg_st_reg_en  = (state == lv_pkg::CFG_ST);
    assign o_dgt_ang_pwm_en = (state == lv_pkg::NORMAL_ST);
    assign o_dgt_ang_fsc_en = (state == lv_pkg::FAULT_ST);   // fail-safe drive
    assign o_intb_n         = intb_q;

    a_fault_pwm_off: assert property (@(posedge i_clk) disable iff (i_reset)
        fault |=> !o_dgt_ang_pwm_en);

endmodule

`default_nettype wire

// ==== hw/lv_analog_int_proc.sv ====
`default_nettype none

module lv_analog_int_proc #(
    parameter int DW = 4
) (
    input  logic          i_clk,
    input  logic          i_reset,
    input  logic          i_lv_pwm_dt,
    input  logic          i_lv_gate_vs_pwm,
    input  logic [DW-1:0] i_vge_mon_dly,
    output logic          o_pwm_dterr,
    output logic          o_pwm_mmerr
);

    logic [1:0]       in_v;
    logic [1:0][DW:0] run_cnt;   // one spare bit so dly+1 fits
    logic [1:0]       err_q;

    assign in_v = {i_lv_gate_vs_pwm, i_lv_pwm_dt};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            run_cnt <= '0;
            err_q   <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // fire once, when the run reaches dly+1
                err_q[i] <= in_v[i] && (run_cnt[i] == {1'b0, i_vge_mon_dly});
                if (!in_v[i]) begin
                    run_cnt[i] <= '0;
                end else if (run_cnt[i] <= {1'b0, i_vge_mon_dly}) begin
                    run_cnt[i] <= run_cnt[i] + 1'b1;   // saturates at dly+1
                end
            end
        end
    end

    assign o_pwm_dterr = err_q[0];
    assign o_pwm_mmerr = err_q[1];

endmodule

`default_nettype wire

// ==== hw/lv_core.sv ====
`default_nettype none

module lv_core (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_spi_sclk,
    input  logic                     i_spi_csb,
    input  logic                     i_spi_mosi,
    output logic                     o_spi_miso,
    input  logic                     i_io_fsenb_n,
    input  logic                     i_lv_vsup_ov,
    input  logic                     i_lv_vsup_uv_n,
    input  logic                     i_lv_pwm_dt,
    input  logic                     i_lv_gate_vs_pwm,
    input  logic                     i_io_pwma,
    input  logic                     i_io_pwm,
    input  logic                     i_io_fsstate,
    input  logic                     i_io_intb,
    input  logic                     i_io_inta,
    output logic                     o_dgt_ang_pwm_en,
    output logic                     o_dgt_ang_fsc_en,
    output logic                     o_intb_n,
    output logic [lv_pkg::DLY_W-1:0] o_vge_mon_dly
);

    logic [2:0]                spi_sync;   // {cs, sclk, mosi}
    logic [5:0]                pin_sync;
    logic [1:0]                ang_sync;
    logic [1:0]                sup_sync;   // {ov, uv}
    logic                      spi_err;
    logic                      pwm_dterr;
    logic                      pwm_mmerr;
    logic                      any_err;
    logic                      cfg_st_reg_en;
    logic [lv_pkg::REG_DW-1:0] rdata;
    logic [lv_pkg::ST_W-1:0]   state;
    lv_pkg::reg_req_t          req;
    lv_pkg::mode_cmd_t         mode_cmd;
    lv_pkg::io_pins_t          pins;
    lv_pkg::lv_err_t           err;

    // ================================================
    // input sync, active low pins inverted so reset idles them
    // ================================================
    lv_in_sync #(.WIDTH(3)) u_spi_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ({~i_spi_csb, i_spi_sclk, i_spi_mosi}),
        .o_data  (spi_sync)
    );

    lv_in_sync #(.WIDTH(6)) u_pin_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ({i_io_pwma, i_io_pwm, i_io_fsstate, ~i_io_fsenb_n, i_io_intb, i_io_inta}),
        .o_data  (pin_sync)
    );

    lv_in_sync #(.WIDTH(2)) u_ang_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ({i_lv_gate_vs_pwm, i_lv_pwm_dt}),
        .o_data  (ang_sync)
    );

    lv_in_sync #(.WIDTH(2)) u_sup_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  ({i_lv_vsup_ov, ~i_lv_vsup_uv_n}),
        .o_data  (sup_sync)
    );

    assign pins = {pin_sync[5:3], ~pin_sync[2], pin_sync[1:0]};
    assign err  = {spi_err, pwm_dterr, pwm_mmerr, 2'b00};   // supply edges found in reg slave

    // ================================================
    // datapath
    // ================================================
    lv_spi_slv u_spi_slv (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_sclk     (spi_sync[1]),
        .i_csb      (~spi_sync[2]),
        .i_mosi     (spi_sync[0]),
        .o_spi_miso (o_spi_miso),
        .o_req      (req),
        .i_rdata    (rdata),
        .o_spi_err  (spi_err)
    );

    lv_reg_slv u_reg_slv (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_req           (req),
        .o_rdata         (rdata),
        .i_err           (err),
        .i_vsup_ov       (sup_sync[1]),
        .i_vsup_uv       (sup_sync[0]),
        .i_pins          (pins),
        .i_state         (state),
        .i_cfg_st_reg_en (cfg_st_reg_en),
        .o_mode_cmd      (mode_cmd),
        .o_any_err       (any_err),
        .o_vge_mon_dly   (o_vge_mon_dly)
    );

    lv_ctrl_unit u_ctrl_unit (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_mode_cmd       (mode_cmd),
        .i_any_err        (any_err),
        .i_io_fsenb_n     (pins.io_fsenb_n),
        .o_state          (state),
        .o_cfg_st_reg_en  (cfg_st_reg_en),
        .o_dgt_ang_pwm_en (o_dgt_ang_pwm_en),
        .o_dgt_ang_fsc_en (o_dgt_ang_fsc_en),
        .o_intb_n         (o_intb_n)
    );

    lv_analog_int_proc #(.DW(lv_pkg::DLY_W)) u_analog_int_proc (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_lv_pwm_dt      (ang_sync[0]),
        .i_lv_gate_vs_pwm (ang_sync[1]),
        .i_vge_mon_dly    (o_vge_mon_dly),
        .o_pwm_dterr      (pwm_dterr),
        .o_pwm_mmerr      (pwm_mmerr)
    );

endmodule

`default_nettype wire

// ==== verif/tb_lv_core.sv ====
`default_nettype none

module tb_lv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PHASE     = 4;   // i_clk cycles per sclk phase
    localparam int WINDOW    = 12;
    localparam int FRAME_CYC = 2 * PHASE * lv_pkg::SPI_FRAME_W + 3 * PHASE + 1;
    localparam int N_FRAMES  = 26;
    localparam int EXTRA_CYC = 300;  // pin activity and output polling
    localparam int TEST_CYC  = N_FRAMES * FRAME_CYC + EXTRA_CYC;

    logic                     i_clk;
    logic                     i_reset;
    logic                     i_spi_sclk;
    logic                     i_spi_csb;
    logic                     i_spi_mosi;
    logic                     o_spi_miso;
    logic                     i_io_fsenb_n;
    logic                     i_lv_vsup_ov;
    logic                     i_lv_vsup_uv_n;
    logic                     i_lv_pwm_dt;
    logic                     i_lv_gate_vs_pwm;
    logic                     i_io_pwma;
    logic                     i_io_pwm;
    logic                     i_io_fsstate;
    logic                     i_io_intb;
    logic                     i_io_inta;
    logic                     o_dgt_ang_pwm_en;
    logic                     o_dgt_ang_fsc_en;
    logic                     o_intb_n;
    logic [lv_pkg::DLY_W-1:0] o_vge_mon_dly;

    logic [15:0] lfsr_q = 16'd42372;
    logic [7:0]  cfg_val;

    lv_core i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    initial begin
        repeat (2 * TEST_CYC) @(posedge i_clk);
        $display("error: watchdog expired after %0d cycles, tests did not finish", 2 * TEST_CYC);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    // ================================================
    // helpers
    // ================================================
    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[15:1]} ^ (fb ? 16'hB400 : 16'h0000);
        return fb;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[6:0], lfsr_bit()};
        end
        return r;
    endfunction

    // mode 0 frame, miso taken just before each rise of bits 9..16
    task automatic shift_frame(input logic [15:0] frame, input int nbits,
                               output logic [7:0] miso_byte);
        miso_byte = '0;
        @(posedge i_clk);
        i_spi_csb  <= 1'b0;
        i_spi_mosi <= frame[15];
        for (int i = 0; i < nbits; i++) begin
            repeat (PHASE - 1) @(posedge i_clk);
            @(negedge i_clk);
            if (i >= 8) begin
                miso_byte = {miso_byte[6:0], o_spi_miso};
            end
            @(posedge i_clk);
            i_spi_sclk <= 1'b1;
            repeat (PHASE) @(posedge i_clk);
            i_spi_sclk <= 1'b0;
            if (i < 15) begin
                i_spi_mosi <= frame[14 - i];   // moves with the fall
            end
        end
        repeat (PHASE) @(posedge i_clk);
        i_spi_csb  <= 1'b1;
        i_spi_mosi <= 1'b0;
        repeat (2 * PHASE) @(posedge i_clk);
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        shift_frame({1'b1, addr, data}, lv_pkg::SPI_FRAME_W, unused);
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [7:0] data);
        shift_frame({1'b0, addr, 8'h00}, lv_pkg::SPI_FRAME_W, data);
    endtask

    task automatic expect_reg(input string name, input logic [6:0] addr, input logic [7:0] exp);
        logic [7:0] got;
        spi_read(addr, got);
        check(name, got, exp);
    endtask

    // poll a bounded window, then compare all three outputs
    task automatic wait_outputs(input logic pwm, input logic fsc, input logic intb);
        int n;
        n = 0;
        @(negedge i_clk);
        while (n < WINDOW &&
               !(o_dgt_ang_pwm_en == pwm && o_dgt_ang_fsc_en == fsc && o_intb_n == intb)) begin
            @(negedge i_clk);
            n++;
        end
        check("o_dgt_ang_pwm_en", o_dgt_ang_pwm_en, pwm);
        check("o_dgt_ang_fsc_en", o_dgt_ang_fsc_en, fsc);
        check("o_intb_n", o_intb_n, intb);
    endtask

    // ================================================
    // directed tests
    // ================================================
    task automatic reset_values();
        @(negedge i_clk);
        check("o_dgt_ang_pwm_en", o_dgt_ang_pwm_en, 1'b0);
        check("o_dgt_ang_fsc_en", o_dgt_ang_fsc_en, 1'b0);
        check("o_intb_n", o_intb_n, 1'b1);
        check("o_spi_miso", o_spi_miso, 1'b0);
        check("o_vge_mon_dly", o_vge_mon_dly, 4'd3);
        expect_reg("STATUS4", lv_pkg::ADDR_STATUS4, {5'b0, lv_pkg::WAIT_ST});
        expect_reg("CONFIG0", lv_pkg::ADDR_CONFIG0, 8'h03);
    endtask

    task automatic config_access();
        spi_write(lv_pkg::ADDR_CONFIG0, 8'hA5);   // locked outside cfg
        expect_reg("CONFIG0", lv_pkg::ADDR_CONFIG0, 8'h03);
        spi_write(lv_pkg::ADDR_MODE, 8'h02);
        wait_outputs(1'b0, 1'b0, 1'b1);
        expect_reg("STATUS4", lv_pkg::ADDR_STATUS4, {5'b0, lv_pkg::CFG_ST});
        cfg_val = rand_bits(8) | 8'h04;   // keeps the filter delay >= 4
        spi_write(lv_pkg::ADDR_CONFIG0, cfg_val);
        expect_reg("CONFIG0", lv_pkg::ADDR_CONFIG0, cfg_val);
        @(negedge i_clk);
        check("o_vge_mon_dly", o_vge_mon_dly, cfg_val[3:0]);
        spi_write(lv_pkg::ADDR_MODE, 8'h01);
        wait_outputs(1'b1, 1'b0, 1'b1);
        expect_reg("STATUS4", lv_pkg::ADDR_STATUS4, {5'b0, lv_pkg::NORMAL_ST});
    endtask

    task automatic analog_filter();
        @(posedge i_clk);
        i_lv_pwm_dt <= 1'b1;
        @(posedge i_clk);
        i_lv_pwm_dt <= 1'b0;   // glitch, shorter than the delay
        repeat (WINDOW) @(posedge i_clk);
        wait_outputs(1'b1, 1'b0, 1'b1);
        expect_reg("STATUS1", lv_pkg::ADDR_STATUS1, 8'h00);
        @(posedge i_clk);
        i_lv_pwm_dt <= 1'b1;
        repeat (40) @(posedge i_clk);
        i_lv_pwm_dt <= 1'b0;
        wait_outputs(1'b0, 1'b1, 1'b0);
        expect_reg("STATUS1", lv_pkg::ADDR_STATUS1, 8'h10);
        expect_reg("STATUS4", lv_pkg::ADDR_STATUS4, {5'b0, lv_pkg::FAULT_ST});
    endtask

    task automatic fault_recovery();
        spi_write(lv_pkg::ADDR_STATUS1, 8'h10);
        wait_outputs(1'b0, 1'b1, 1'b1);   // still in fault until reset_en
        expect_reg("STATUS1", lv_pkg::ADDR_STATUS1, 8'h00);
        spi_write(lv_pkg::ADDR_MODE, 8'h04);
        wait_outputs(1'b0, 1'b0, 1'b1);
        expect_reg("STATUS4", lv_pkg::ADDR_STATUS4, {5'b0, lv_pkg::WAIT_ST});
    endtask

    task automatic pins_and_supply();
        logic [7:0] rnd;
        logic [5:0] pat;
        rnd = rand_bits(6);
        pat = rnd[5:0];
        @(posedge i_clk);
        {i_io_pwma, i_io_pwm, i_io_fsstate, i_io_fsenb_n, i_io_intb, i_io_inta} <= pat;
        expect_reg("STATUS3", lv_pkg::ADDR_STATUS3, {2'b00, pat});
        @(posedge i_clk);
        i_lv_vsup_ov <= 1'b1;
        wait_outputs(1'b0, 1'b1, 1'b0);
        expect_reg("STATUS2", lv_pkg::ADDR_STATUS2, 8'h02);
        @(posedge i_clk);
        i_lv_vsup_ov <= 1'b0;
        {i_io_pwma, i_io_pwm, i_io_fsstate, i_io_fsenb_n, i_io_intb, i_io_inta} <= 6'b000100;
        spi_write(lv_pkg::ADDR_STATUS2, 8'h02);
        wait_outputs(1'b0, 1'b1, 1'b1);
    endtask

    task automatic cut_frame();
        logic [7:0] unused;
        spi_write(lv_pkg::ADDR_MODE, 8'h04);
        wait_outputs(1'b0, 1'b0, 1'b1);
        spi_write(lv_pkg::ADDR_MODE, 8'h02);
        wait_outputs(1'b0, 1'b0, 1'b1);
        expect_reg("STATUS4", lv_pkg::ADDR_STATUS4, {5'b0, lv_pkg::CFG_ST});
        // config write dropped after 10 bits
        shift_frame({1'b1, lv_pkg::ADDR_CONFIG0, ~cfg_val}, 10, unused);
        expect_reg("STATUS1", lv_pkg::ADDR_STATUS1, 8'h01);
        expect_reg("CONFIG0", lv_pkg::ADDR_CONFIG0, cfg_val);
    endtask

    initial begin
        i_reset          <= 1'b1;
        i_spi_sclk       <= 1'b0;
        i_spi_csb        <= 1'b1;
        i_spi_mosi       <= 1'b0;
        i_io_fsenb_n     <= 1'b1;
        i_lv_vsup_ov     <= 1'b0;
        i_lv_vsup_uv_n   <= 1'b1;
        i_lv_pwm_dt      <= 1'b0;
        i_lv_gate_vs_pwm <= 1'b0;
        i_io_pwma        <= 1'b0;
        i_io_pwm         <= 1'b0;
        i_io_fsstate     <= 1'b0;
        i_io_intb        <= 1'b0;
        i_io_inta        <= 1'b0;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (4) @(posedge i_clk);

        reset_values();
        config_access();
        analog_filter();
        fault_recovery();
        pins_and_supply();
        cut_frame();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lv_core.f ====
hw/lv_pkg.sv
hw/lv_in_sync.sv
hw/lv_spi_slv.sv
hw/lv_reg_slv.sv
hw/lv_ctrl_unit.sv
hw/lv_analog_int_proc.sv
hw/lv_core.sv
verif/tb_lv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_lv_core \
    -f lv_core.f \
    -o tb_lv_core

./obj_dir/tb_lv_core
